// File: rtl/cpu_pkg.sv
package cpu_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and basic types
    ////////////////////////////////////////////////////////////

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // First fetch after reset
    localparam word_t reset_pc = '0;

    ////////////////////////////////////////////////////////////
    // Instruction encodings
    ////////////////////////////////////////////////////////////

    // Primary opcodes
    localparam logic [5:0] op_rtype = 6'h00;
    localparam logic [5:0] op_beq   = 6'h04;
    localparam logic [5:0] op_bne   = 6'h05;
    localparam logic [5:0] op_addiu = 6'h09;
    localparam logic [5:0] op_andi  = 6'h0c;
    localparam logic [5:0] op_ori   = 6'h0d;
    localparam logic [5:0] op_lui   = 6'h0f;
    localparam logic [5:0] op_lw    = 6'h23;
    localparam logic [5:0] op_sw    = 6'h2b;

    // Funct field of R-type
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        imm_sign,
        imm_zero,
        imm_upper
    } imm_kind_e;

    ////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic    reg_we;
        logic    mem_re;
        logic    mem_we;
        logic    branch;
        logic    branch_ne;
        alu_op_e alu_op;
        logic    b_is_imm;
    } ctrl_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc_4;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
    } idex_t;

    typedef struct packed {
        logic      reg_we;
        logic      mem_re;
        logic      mem_we;
        reg_addr_t rd;
        word_t     alu_res;
        word_t     store_data;
        logic      taken;
        word_t     target;
    } exmem_t;

    typedef struct packed {
        logic      reg_we;
        reg_addr_t rd;
        word_t     wb_data;
    } memwb_t;

endpackage

// File: rtl/pipe_ctrl_if.sv
`timescale 1ns/1ps

interface pipe_ctrl_if (
    input logic clk,
    input logic arst_n
);
    // From hazard unit
    logic               stall;
    logic               redirect;
    cpu_pkg::word_t     redirect_pc;

    // Load sitting in ID/EX
    logic               load_pending;
    cpu_pkg::reg_addr_t load_rd;

    modport hazard (
        input  clk, arst_n, load_pending, load_rd,
        output stall, redirect, redirect_pc
    );

    modport fetch (
        input stall, redirect, redirect_pc
    );

endinterface

// File: rtl/fwd_if.sv
`timescale 1ns/1ps

interface fwd_if (
    input logic clk
);
    // EX/MEM producer, write enable already qualified by valid
    logic               ex_we;
    cpu_pkg::reg_addr_t ex_rd;
    cpu_pkg::word_t     ex_data;

    // MEM/WB producer
    logic               wb_we;
    cpu_pkg::reg_addr_t wb_rd;
    cpu_pkg::word_t     wb_data;

    modport source (
        output ex_we, ex_rd, ex_data, wb_we, wb_rd, wb_data
    );

    modport sink (
        input clk, ex_we, ex_rd, ex_data, wb_we, wb_rd, wb_data
    );

endinterface

// File: rtl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    input  logic     d_valid,
    output payload_t q,
    output logic     q_valid
);

    // Valid bit
    // Flush empties the slot and stall freezes it
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q_valid <= 1'b0;
        end else if (flush) begin
            q_valid <= 1'b0;
        end else if (!stall) begin
            q_valid <= d_valid;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (!flush && !stall) begin
            q <= d;
        end
    end

    // Slot controls come from qualified logic and are never X once out of reset
    a_ctrl_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown({stall, flush, d_valid})
    );

endmodule

// File: rtl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
    input  logic           clk,
    input  logic           arst_n,
    pipe_ctrl_if.fetch     ctrl,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_rdata,
    output cpu_pkg::word_t id_instr,
    output cpu_pkg::word_t id_pc_4,
    output logic           id_valid
);

    cpu_pkg::word_t             pc;
    cpu_pkg::word_t             pc_4;
    logic [2*cpu_pkg::xlen-1:0] ifid_q;

    // Sequential fetch
    assign pc_4      = pc + 32'd4;
    assign imem_addr = pc;

    // PC register
    // Redirect first, then stall hold, else fall through
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= cpu_pkg::reset_pc;
        end else if (ctrl.redirect) begin
            pc <= ctrl.redirect_pc;
        end else if (!ctrl.stall) begin
            pc <= pc_4;
        end
    end

    // IF/ID register
    // Instruction word in the upper half, pc+4 below
    stage_reg #(
        .payload_t (logic [2*cpu_pkg::xlen-1:0])
    ) u_ifid (
        .clk     (clk),
        .arst_n  (arst_n),
        .stall   (ctrl.stall),
        .flush   (ctrl.redirect),
        .d       ({imem_rdata, pc_4}),
        .d_valid (1'b1),
        .q       (ifid_q),
        .q_valid (id_valid)
    );

    assign id_instr = ifid_q[2*cpu_pkg::xlen-1:cpu_pkg::xlen];
    assign id_pc_4  = ifid_q[cpu_pkg::xlen-1:0];

endmodule

// File: rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::word_t     instr,
    input  logic               valid,
    output cpu_pkg::ctrl_t     ctrl,
    output cpu_pkg::word_t     imm,
    output cpu_pkg::reg_addr_t rs,
    output cpu_pkg::reg_addr_t rt,
    output cpu_pkg::reg_addr_t rd,
    output logic               uses_rt
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    logic [15:0]        imm16;
    cpu_pkg::imm_kind_e imm_kind;
    cpu_pkg::ctrl_t     dec;

    // Field split
    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign imm16  = instr[15:0];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];

    ////////////////////////////////////////////////////////////
    // Opcode and funct decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        dec      = '0;
        imm_kind = cpu_pkg::imm_sign;
        rd       = rt;
        uses_rt  = 1'b0;
        case (opcode)
            cpu_pkg::op_rtype: begin
                // R-type writes the rd field
                rd         = instr[15:11];
                uses_rt    = 1'b1;
                dec.reg_we = 1'b1;
                case (funct)
                    cpu_pkg::fn_addu: dec.alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_subu: dec.alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and:  dec.alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:   dec.alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_xor:  dec.alu_op = cpu_pkg::alu_xor;
                    cpu_pkg::fn_slt:  dec.alu_op = cpu_pkg::alu_slt;
                    default:          dec.reg_we = 1'b0;
                endcase
            end
            cpu_pkg::op_addiu: begin
                dec.reg_we   = 1'b1;
                dec.b_is_imm = 1'b1;
            end
            cpu_pkg::op_andi: begin
                dec.reg_we   = 1'b1;
                dec.b_is_imm = 1'b1;
                dec.alu_op   = cpu_pkg::alu_and;
                imm_kind     = cpu_pkg::imm_zero;
            end
            cpu_pkg::op_ori: begin
                dec.reg_we   = 1'b1;
                dec.b_is_imm = 1'b1;
                dec.alu_op   = cpu_pkg::alu_or;
                imm_kind     = cpu_pkg::imm_zero;
            end
            cpu_pkg::op_lui: begin
                dec.reg_we   = 1'b1;
                dec.b_is_imm = 1'b1;
                dec.alu_op   = cpu_pkg::alu_lui;
                imm_kind     = cpu_pkg::imm_upper;
            end
            cpu_pkg::op_lw: begin
                // Address is rs + sign-extended offset
                dec.reg_we   = 1'b1;
                dec.mem_re   = 1'b1;
                dec.b_is_imm = 1'b1;
            end
            cpu_pkg::op_sw: begin
                dec.mem_we   = 1'b1;
                dec.b_is_imm = 1'b1;
                uses_rt      = 1'b1;
            end
            cpu_pkg::op_beq: begin
                dec.branch = 1'b1;
                uses_rt    = 1'b1;
            end
            cpu_pkg::op_bne: begin
                dec.branch    = 1'b1;
                dec.branch_ne = 1'b1;
                uses_rt       = 1'b1;
            end
            default: begin
                // Unknown opcode stays a no-op
                dec = '0;
            end
        endcase
    end

    // Bubble carries nothing
    // Write to r0 dropped here so later stages never see it
    always_comb begin
        if (valid) begin
            ctrl = dec;
        end else begin
            ctrl = '0;
        end
        if (rd == '0) begin
            ctrl.reg_we = 1'b0;
        end
    end

    // Immediate extension
    always_comb begin
        case (imm_kind)
            cpu_pkg::imm_zero:  imm = {16'h0000, imm16};
            cpu_pkg::imm_upper: imm = {imm16, 16'h0000};
            default:            imm = {{16{imm16[15]}}, imm16};
        endcase
    end

endmodule

// File: rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::reg_addr_t rs,
    input  cpu_pkg::reg_addr_t rt,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    input  logic               we,
    input  cpu_pkg::reg_addr_t wd_addr,
    input  cpu_pkg::word_t     wd_data
);

    cpu_pkg::word_t regs [32];

    // Write port, r0 never written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wd_addr != '0) begin
            regs[wd_addr] <= wd_data;
        end
    end

    // One read port
    // WB value passes straight through in its own cycle
    function automatic cpu_pkg::word_t read_port(input cpu_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we && wd_addr == addr) begin
            return wd_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs);
        rt_data = read_port(rt);
    end

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  cpu_pkg::idex_t  ex,
    fwd_if.sink             fwd,
    output cpu_pkg::exmem_t res
);

    cpu_pkg::word_t op_a;
    cpu_pkg::word_t rt_fwd;
    cpu_pkg::word_t op_b;
    cpu_pkg::word_t alu_out;

    ////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////

    // Youngest producer first
    assign op_a = (fwd.ex_we && fwd.ex_rd == ex.rs) ? fwd.ex_data :
                  (fwd.wb_we && fwd.wb_rd == ex.rs) ? fwd.wb_data : ex.rs_data;

    assign rt_fwd = (fwd.ex_we && fwd.ex_rd == ex.rt) ? fwd.ex_data :
                    (fwd.wb_we && fwd.wb_rd == ex.rt) ? fwd.wb_data : ex.rt_data;

    // Immediate replaces rt for I-type
    assign op_b = ex.ctrl.b_is_imm ? ex.imm : rt_fwd;

    // ALU
    always_comb begin
        case (ex.ctrl.alu_op)
            cpu_pkg::alu_add: alu_out = op_a + op_b;
            cpu_pkg::alu_sub: alu_out = op_a - op_b;
            cpu_pkg::alu_and: alu_out = op_a & op_b;
            cpu_pkg::alu_or:  alu_out = op_a | op_b;
            cpu_pkg::alu_xor: alu_out = op_a ^ op_b;
            cpu_pkg::alu_slt: alu_out = {{(cpu_pkg::xlen-1){1'b0}},
                                         $signed(op_a) < $signed(op_b)};
            cpu_pkg::alu_lui: alu_out = op_b;
            default:          alu_out = op_a + op_b;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // EX/MEM payload
    ////////////////////////////////////////////////////////////

    always_comb begin
        res.reg_we     = ex.ctrl.reg_we;
        res.mem_re     = ex.ctrl.mem_re;
        res.mem_we     = ex.ctrl.mem_we;
        res.rd         = ex.rd;
        res.alu_res    = alu_out;
        // Store data uses the forwarded rt
        res.store_data = rt_fwd;
        // beq on equal, bne on not equal
        res.taken      = ex.ctrl.branch && ((op_a == rt_fwd) ^ ex.ctrl.branch_ne);
        res.target     = ex.pc_4 + {ex.imm[cpu_pkg::xlen-3:0], 2'b00};
    end

    // Decoder strips r0 writes so no producer ever claims r0
    a_no_r0_fwd : assert property (
        @(posedge fwd.clk)
        (fwd.ex_we |-> fwd.ex_rd != '0) and (fwd.wb_we |-> fwd.wb_rd != '0)
    );

endmodule

// File: rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    pipe_ctrl_if.hazard        ctrl,
    input  cpu_pkg::reg_addr_t id_rs,
    input  cpu_pkg::reg_addr_t id_rt,
    input  logic               id_uses_rt,
    input  logic               mem_taken,
    input  cpu_pkg::word_t     mem_target
);

    logic rs_hit;
    logic rt_hit;

    // Load-use check against the instruction in ID
    assign rs_hit = ctrl.load_rd == id_rs;
    assign rt_hit = id_uses_rt && ctrl.load_rd == id_rt;

    // One bubble while the load is in EX
    assign ctrl.stall = ctrl.load_pending && ctrl.load_rd != '0 && (rs_hit || rt_hit);

    // Taken branch in MEM
    assign ctrl.redirect    = mem_taken;
    assign ctrl.redirect_pc = mem_target;

    // EX/MEM flush on redirect keeps it to one pulse
    a_redirect_pulse : assert property (
        @(posedge ctrl.clk) disable iff (!ctrl.arst_n)
        ctrl.redirect |=> !ctrl.redirect
    );

endmodule

// File: rtl/pipeline.sv
`timescale 1ns/1ps

module pipeline (
    input  logic           clk,
    input  logic           arst_n,
    output cpu_pkg::word_t imem_addr,
    input  cpu_pkg::word_t imem_rdata,
    output cpu_pkg::word_t dmem_addr,
    output cpu_pkg::word_t dmem_wdata,
    output logic           dmem_re,
    output logic           dmem_we,
    input  cpu_pkg::word_t dmem_rdata
);

    // ID
    cpu_pkg::word_t     id_instr;
    cpu_pkg::word_t     id_pc_4;
    logic               id_valid;
    cpu_pkg::ctrl_t     id_ctrl;
    cpu_pkg::word_t     id_imm;
    cpu_pkg::reg_addr_t id_rs;
    cpu_pkg::reg_addr_t id_rt;
    cpu_pkg::reg_addr_t id_rd;
    logic               id_uses_rt;
    cpu_pkg::word_t     id_rs_data;
    cpu_pkg::word_t     id_rt_data;
    cpu_pkg::idex_t     id_out;

    // EX
    cpu_pkg::idex_t     ex_in;
    logic               ex_valid;
    cpu_pkg::exmem_t    ex_out;

    // MEM
    cpu_pkg::exmem_t    mem_in;
    logic               mem_valid;
    cpu_pkg::memwb_t    mem_out;

    // WB
    cpu_pkg::memwb_t    wb_in;
    logic               wb_valid;

    pipe_ctrl_if pc_if (.clk(clk), .arst_n(arst_n));
    fwd_if       fw_if (.clk(clk));

    ////////////////////////////////////////////////////////////
    // IF
    ////////////////////////////////////////////////////////////

    fetch_unit u_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (pc_if.fetch),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .id_instr   (id_instr),
        .id_pc_4    (id_pc_4),
        .id_valid   (id_valid)
    );

    ////////////////////////////////////////////////////////////
    // ID
    ////////////////////////////////////////////////////////////

    decoder u_dec (
        .instr   (id_instr),
        .valid   (id_valid),
        .ctrl    (id_ctrl),
        .imm     (id_imm),
        .rs      (id_rs),
        .rt      (id_rt),
        .rd      (id_rd),
        .uses_rt (id_uses_rt)
    );

    // Written from MEM/WB
    reg_file u_rf (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs      (id_rs),
        .rt      (id_rt),
        .rs_data (id_rs_data),
        .rt_data (id_rt_data),
        .we      (fw_if.wb_we),
        .wd_addr (wb_in.rd),
        .wd_data (wb_in.wb_data)
    );

    always_comb begin
        id_out.ctrl    = id_ctrl;
        id_out.pc_4    = id_pc_4;
        id_out.rs_data = id_rs_data;
        id_out.rt_data = id_rt_data;
        id_out.imm     = id_imm;
        id_out.rs      = id_rs;
        id_out.rt      = id_rt;
        id_out.rd      = id_rd;
    end

    hazard_unit u_haz (
        .ctrl       (pc_if.hazard),
        .id_rs      (id_rs),
        .id_rt      (id_rt),
        .id_uses_rt (id_uses_rt),
        .mem_taken  (mem_valid && mem_in.taken),
        .mem_target (mem_in.target)
    );

    // Load in EX seen by the hazard unit
    assign pc_if.load_pending = ex_valid && ex_in.ctrl.mem_re;
    assign pc_if.load_rd      = ex_in.rd;

    // Stall turns ID/EX into a bubble
    stage_reg #(.payload_t(cpu_pkg::idex_t)) u_idex (
        .clk     (clk),
        .arst_n  (arst_n),
        .stall   (1'b0),
        .flush   (pc_if.redirect || pc_if.stall),
        .d       (id_out),
        .d_valid (id_valid),
        .q       (ex_in),
        .q_valid (ex_valid)
    );

    ////////////////////////////////////////////////////////////
    // EX
    ////////////////////////////////////////////////////////////

    execute_unit u_ex (
        .ex  (ex_in),
        .fwd (fw_if.sink),
        .res (ex_out)
    );

    stage_reg #(.payload_t(cpu_pkg::exmem_t)) u_exmem (
        .clk     (clk),
        .arst_n  (arst_n),
        .stall   (1'b0),
        .flush   (pc_if.redirect),
        .d       (ex_out),
        .d_valid (ex_valid),
        .q       (mem_in),
        .q_valid (mem_valid)
    );

    ////////////////////////////////////////////////////////////
    // MEM
    ////////////////////////////////////////////////////////////

    // Data memory port
    assign dmem_addr  = mem_in.alu_res;
    assign dmem_wdata = mem_in.store_data;
    assign dmem_re    = mem_valid && mem_in.mem_re;
    assign dmem_we    = mem_valid && mem_in.mem_we;

    // Load data arrives in the same cycle
    assign mem_out.reg_we  = mem_in.reg_we;
    assign mem_out.rd      = mem_in.rd;
    assign mem_out.wb_data = mem_in.mem_re ? dmem_rdata : mem_in.alu_res;

    stage_reg #(.payload_t(cpu_pkg::memwb_t)) u_memwb (
        .clk     (clk),
        .arst_n  (arst_n),
        .stall   (1'b0),
        .flush   (1'b0),
        .d       (mem_out),
        .d_valid (mem_valid),
        .q       (wb_in),
        .q_valid (wb_valid)
    );

    // Forwarding sources
    assign fw_if.ex_we   = mem_valid && mem_in.reg_we;
    assign fw_if.ex_rd   = mem_in.rd;
    assign fw_if.ex_data = mem_in.alu_res;
    assign fw_if.wb_we   = wb_valid && wb_in.reg_we;
    assign fw_if.wb_rd   = wb_in.rd;
    assign fw_if.wb_data = wb_in.wb_data;

endmodule

// File: verif/pipeline_tb.sv
`timescale 1ns/1ps

module pipeline_tb;

    logic           clk;
    logic           arst_n;
    cpu_pkg::word_t imem_addr;
    cpu_pkg::word_t imem_rdata;
    cpu_pkg::word_t dmem_addr;
    cpu_pkg::word_t dmem_wdata;
    logic           dmem_re;
    logic           dmem_we;
    cpu_pkg::word_t dmem_rdata;

    // Word-addressed memories of 256 words each
    cpu_pkg::word_t imem [256];
    cpu_pkg::word_t dmem [256];

    // Program table and expected stores in program order
    cpu_pkg::word_t prog [$];
    cpu_pkg::word_t exp_addr [$];
    cpu_pkg::word_t exp_data [$];

    // Load addresses in program order
    cpu_pkg::word_t exp_load [$];

    // Architectural register values by the ISA rules
    cpu_pkg::word_t gr [32];

    integer         seed        = 32'hc01f_b069;
    int             mismatches  = 0;
    int             other_errs  = 0;
    int             store_idx   = 0;
    int             load_idx    = 0;
    int             hold_cycles = 0;
    int             exp_stalls  = 0;
    int             loop_hits   = 0;
    logic           running     = 1'b0;
    cpu_pkg::word_t prev_addr   = '1;
    cpu_pkg::word_t loop_addr;

    pipeline UUT (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_re    (dmem_re),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////////////////////////

    function automatic cpu_pkg::word_t rtype(input logic [5:0] fn, input int rd,
                                             input int rs, input int rt);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    // Assembly operand order with rt before rs
    function automatic cpu_pkg::word_t itype(input logic [5:0] op, input int rt,
                                             input int rs, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic expect_store(input cpu_pkg::word_t addr, input cpu_pkg::word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Branch over three stores of r1..r3
    // Stores only expected when the branch falls through
    task automatic branch_block(input logic [5:0] op, input int rs, input int rt,
                                input int base);
        logic taken;
        taken = (gr[rs] == gr[rt]) ^ (op == cpu_pkg::op_bne);
        prog.push_back(itype(op, rt, rs, 3));
        for (int k = 1; k <= 3; k++) begin
            prog.push_back(itype(cpu_pkg::op_sw, k, 0, base + 4 * k));
            if (!taken) begin
                expect_store(base + 4 * k, gr[k]);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Program table
    ////////////////////////////////////////////////////////////

    task automatic build_program();
        for (int i = 0; i < 32; i++) begin
            gr[i] = '0;
        end

        // ALU chain where each result feeds the next
        prog.push_back(itype(cpu_pkg::op_addiu, 1, 0, 'h1234));
        gr[1] = 32'h0000_1234;
        prog.push_back(itype(cpu_pkg::op_addiu, 2, 1, -4));
        gr[2] = gr[1] + 32'hffff_fffc;
        prog.push_back(rtype(cpu_pkg::fn_addu, 3, 1, 2));
        gr[3] = gr[1] + gr[2];
        prog.push_back(rtype(cpu_pkg::fn_subu, 4, 3, 1));
        gr[4] = gr[3] - gr[1];
        prog.push_back(itype(cpu_pkg::op_lui, 5, 0, 'hdead));
        gr[5] = 32'hdead_0000;
        prog.push_back(itype(cpu_pkg::op_ori, 5, 5, 'hbeef));
        gr[5] = gr[5] | 32'h0000_beef;
        prog.push_back(rtype(cpu_pkg::fn_and, 6, 5, 3));
        gr[6] = gr[5] & gr[3];
        prog.push_back(rtype(cpu_pkg::fn_or, 7, 6, 4));
        gr[7] = gr[6] | gr[4];
        prog.push_back(rtype(cpu_pkg::fn_xor, 8, 7, 5));
        gr[8] = gr[7] ^ gr[5];
        prog.push_back(rtype(cpu_pkg::fn_slt, 9, 5, 1));
        gr[9] = ($signed(gr[5]) < $signed(gr[1])) ? 32'd1 : 32'd0;
        prog.push_back(rtype(cpu_pkg::fn_slt, 10, 1, 5));
        gr[10] = ($signed(gr[1]) < $signed(gr[5])) ? 32'd1 : 32'd0;
        prog.push_back(itype(cpu_pkg::op_andi, 11, 5, 'hff00));
        gr[11] = gr[5] & 32'h0000_ff00;
        prog.push_back(itype(cpu_pkg::op_addiu, 12, 11, 1));
        gr[12] = gr[11] + 32'd1;

        // Newest first so the r12 store needs its data forwarded
        for (int r = 12; r >= 2; r--) begin
            prog.push_back(itype(cpu_pkg::op_sw, r, 0, 'h200 + 4 * r));
            expect_store(32'h200 + 4 * r, gr[r]);
        end

        // Load followed directly by its consumer
        prog.push_back(itype(cpu_pkg::op_lw, 13, 0, 0));
        exp_load.push_back(32'h0);
        gr[13] = dmem[0];
        prog.push_back(rtype(cpu_pkg::fn_addu, 14, 13, 1));
        gr[14] = gr[13] + gr[1];
        exp_stalls++;
        prog.push_back(itype(cpu_pkg::op_lw, 15, 0, 4));
        exp_load.push_back(32'h4);
        gr[15] = dmem[1];
        prog.push_back(rtype(cpu_pkg::fn_addu, 16, 15, 13));
        gr[16] = gr[15] + gr[13];
        exp_stalls++;
        prog.push_back(itype(cpu_pkg::op_lw, 17, 0, 8));
        exp_load.push_back(32'h8);
        gr[17] = dmem[2];
        prog.push_back(rtype(cpu_pkg::fn_addu, 18, 14, 17));
        gr[18] = gr[14] + gr[17];
        exp_stalls++;
        // Store data straight from a load
        prog.push_back(itype(cpu_pkg::op_lw, 19, 0, 12));
        exp_load.push_back(32'hc);
        gr[19] = dmem[3];
        prog.push_back(itype(cpu_pkg::op_sw, 19, 0, 'h240));
        expect_store(32'h240, gr[19]);
        exp_stalls++;
        prog.push_back(itype(cpu_pkg::op_sw, 14, 0, 'h244));
        expect_store(32'h244, gr[14]);
        prog.push_back(itype(cpu_pkg::op_sw, 16, 0, 'h248));
        expect_store(32'h248, gr[16]);
        prog.push_back(itype(cpu_pkg::op_sw, 18, 0, 'h24c));
        expect_store(32'h24c, gr[18]);

        // Two not taken and then two taken
        branch_block(cpu_pkg::op_beq, 1, 2, 'h300);
        branch_block(cpu_pkg::op_bne, 3, 3, 'h320);
        branch_block(cpu_pkg::op_beq, 2, 4, 'h340);
        branch_block(cpu_pkg::op_bne, 1, 5, 'h360);
        // Branch operand forwarded from EX/MEM
        prog.push_back(itype(cpu_pkg::op_addiu, 20, 0, 7));
        gr[20] = 32'd7;
        branch_block(cpu_pkg::op_bne, 20, 0, 'h380);

        // r0 stays zero on the forwarding path too
        prog.push_back(itype(cpu_pkg::op_addiu, 0, 1, 'h55));
        prog.push_back(itype(cpu_pkg::op_sw, 0, 0, 'h250));
        expect_store(32'h250, gr[0]);
        prog.push_back(rtype(cpu_pkg::fn_addu, 0, 1, 1));
        prog.push_back(itype(cpu_pkg::op_sw, 0, 0, 'h254));
        expect_store(32'h254, gr[0]);
        prog.push_back(itype(cpu_pkg::op_sw, 20, 0, 'h258));
        expect_store(32'h258, gr[20]);

        // Final loop branches to itself
        prog.push_back(itype(cpu_pkg::op_beq, 0, 0, -1));
    endtask

    ////////////////////////////////////////////////////////////
    // Memory models and monitors
    ////////////////////////////////////////////////////////////

    task automatic check_store();
        assert (store_idx < exp_addr.size()) else begin
            other_errs++;
            $display("store of %h to address %h was not expected", dmem_wdata, dmem_addr);
        end
        if (store_idx < exp_addr.size()) begin
            assert (dmem_addr == exp_addr[store_idx]) else begin
                mismatches++;
                $display("mismatch dmem_addr (store %0d): got %h, expected %h",
                         store_idx, dmem_addr, exp_addr[store_idx]);
            end
            assert (dmem_wdata == exp_data[store_idx]) else begin
                mismatches++;
                $display("mismatch dmem_wdata (store %0d): got %h, expected %h",
                         store_idx, dmem_wdata, exp_data[store_idx]);
            end
        end
        dmem[dmem_addr[9:2]] = dmem_wdata;
        store_idx++;
    endtask

    task automatic check_load();
        if (load_idx < exp_load.size()) begin
            assert (dmem_addr == exp_load[load_idx]) else begin
                mismatches++;
                $display("mismatch dmem_addr (load %0d): got %h, expected %h",
                         load_idx, dmem_addr, exp_load[load_idx]);
            end
        end
        load_idx++;
    endtask

    // Mid-cycle answers sampled by the DUT on the next rising edge
    always @(negedge clk) begin
        imem_rdata <= imem[imem_addr[9:2]];
        dmem_rdata <= dmem[dmem_addr[9:2]];
        if (running) begin
            // PC held for a cycle means a stall
            if (imem_addr == prev_addr) begin
                hold_cycles++;
            end
            prev_addr = imem_addr;
            if (imem_addr == loop_addr) begin
                loop_hits++;
            end
            if (dmem_re) begin
                check_load();
            end
            if (dmem_we) begin
                check_store();
            end
        end
    end

    // Watchdog allows ten cycles per instruction
    initial begin
        wait (running);
        repeat (prog.size() * 10) @(posedge clk);
        $display("watchdog expired before the program reached its final loop");
        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errs + 1);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        arst_n     = 1'b0;
        imem_rdata = '0;
        dmem_rdata = '0;

        // Random data words where loads read the first four
        for (int i = 0; i < 256; i++) begin
            dmem[i] = $random(seed);
        end
        build_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : '0;
        end
        loop_addr = (prog.size() - 1) * 4;

        // No memory strobes while in reset
        for (int c = 0; c < 16; c++) begin
            @(negedge clk);
            assert (dmem_we === 1'b0 && dmem_re === 1'b0) else begin
                other_errs++;
                $display("data memory strobe active during reset at %0t", $time);
            end
            assert (imem_addr === 32'h0) else begin
                mismatches++;
                $display("mismatch imem_addr: got %h, expected %h", imem_addr, 32'h0);
            end
        end
        arst_n  <= 1'b1;
        running <= 1'b1;

        // Second visit of the loop means every store has passed MEM
        wait (loop_hits >= 2);
        @(negedge clk);

        assert (store_idx == exp_addr.size()) else begin
            mismatches++;
            $display("mismatch store_count: got %h, expected %h", store_idx, exp_addr.size());
        end
        assert (load_idx == exp_load.size()) else begin
            mismatches++;
            $display("mismatch load_count: got %h, expected %h", load_idx, exp_load.size());
        end
        assert (hold_cycles == exp_stalls) else begin
            mismatches++;
            $display("mismatch fetch_hold_cycles: got %h, expected %h",
                     hold_cycles, exp_stalls);
        end

        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
rtl/cpu_pkg.sv
rtl/pipe_ctrl_if.sv
rtl/fwd_if.sv
rtl/stage_reg.sv
rtl/fetch_unit.sv
rtl/decoder.sv
rtl/reg_file.sv
rtl/execute_unit.sv
rtl/hazard_unit.sv
rtl/pipeline.sv
verif/pipeline_tb.sv
